// File: Bender.yml
package:
  name: wisc_core

sources:
  - design/wiscPkg.sv
  - design/wiscDecode.sv
  - design/wiscExecute.sv
  - design/wiscResult.sv
  - design/wiscCoreTop.sv
  - target: test
    files:
      - dv/tb.sv

// File: design/wiscCoreTop.sv
`timescale 1ns/1ps
`default_nettype none

module wiscCoreTop (
    input  logic                    clk,
    input  logic                    arstN,
    // APB slave
    input  logic                    PSEL,
    input  logic                    PENABLE,
    input  logic                    PWRITE,
    input  logic [wiscPkg::addrW-1:0] PADDR,
    input  logic [15:0]             PWDATA,
    output logic [15:0]             PRDATA,
    output logic                    PREADY,
    output logic                    PSLVERR,
    // Accelerator
    input  logic                    fftBusy,
    output logic                    startF,
    output logic                    startI,
    output logic                    loadF
);

    wiscPkg::ctrlT  ctrl;
    wiscPkg::exResT exRes;
    logic [15:0] rsValue;
    logic [15:0] rtValue;
    logic [15:0] pc;
    logic [15:0] readValue;
    logic        halted;
    logic        lastTaken;
    logic        access;
    logic        isIssue;
    logic        isReg;
    logic        isPc;
    logic        isStatus;
    logic        badAddr;
    logic        issueWr;
    logic        blocked;
    logic        commit;

    assign access = PSEL && PENABLE;

    // Address decode, 0x20..0x3C covers the eight registers
    assign isIssue = (PADDR == wiscPkg::addrIssue);
    assign isReg = (PADDR[7:5] == wiscPkg::addrRegBase[7:5]) && (PADDR[1:0] == 2'b00);
    assign isPc = (PADDR == wiscPkg::addrPc);
    assign isStatus = (PADDR == wiscPkg::addrStatus);
    // Writes go only to the issue port, reads only to state
    assign badAddr = PWRITE ? !isIssue : !(isReg || isPc || isStatus);

    assign issueWr = access && PWRITE && isIssue;
    // Busy accelerator stretches the access phase
    assign blocked = issueWr && !halted && ctrl.blockInstruction;
    assign commit = issueWr && !halted && !ctrl.blockInstruction;

    assign PREADY = access && !blocked;
    assign PSLVERR = PREADY && (badAddr || (issueWr && halted));

    // Read mux
    always_comb begin
        if (isReg) begin
            PRDATA = readValue;
        end else if (isPc) begin
            PRDATA = pc;
        end else if (isStatus) begin
            PRDATA = {14'b0, lastTaken, halted};
        end else begin
            PRDATA = '0;
        end
    end

    // Pulses fire only on the completing cycle
    assign startF = commit && ctrl.startF;
    assign startI = commit && ctrl.startI;
    assign loadF = commit && ctrl.loadF;

    wiscDecode decodeU (
        .opcode         (wiscPkg::opcodeE'(PWDATA[15:11])),
        .fftCalculating (fftBusy),
        .ctrl           (ctrl)
    );

    wiscExecute executeU (
        .ctrl    (ctrl),
        .instr   (PWDATA),
        .rsValue (rsValue),
        .rtValue (rtValue),
        .pc      (pc),
        .exRes   (exRes)
    );

    wiscResult resultU (
        .clk       (clk),
        .arstN     (arstN),
        .commit    (commit),
        .ctrl      (ctrl),
        .instr     (PWDATA),
        .exRes     (exRes),
        .rsValue   (rsValue),
        .rtValue   (rtValue),
        .readIdx   (PADDR[4:2]),
        .readValue (readValue),
        .pc        (pc),
        .halted    (halted),
        .lastTaken (lastTaken)
    );

    // Ready only in an access phase that followed a setup phase
    assert property (@(posedge clk) disable iff (!arstN)
        PREADY |-> (PSEL && PENABLE && $past(PSEL)))
        else $error("PREADY outside an APB access phase");

endmodule

`default_nettype wire

// File: design/wiscDecode.sv
`timescale 1ns/1ps
`default_nettype none

module wiscDecode (
    input  wiscPkg::opcodeE opcode,
    // Accelerator still busy with the previous job
    input  logic            fftCalculating,
    output wiscPkg::ctrlT   ctrl
);

    always_comb begin
        // Everything off unless the opcode asks for it
        ctrl = '0;
        case (opcode)
            wiscPkg::HALT: begin
                ctrl.halt = 1'b1;
            end
            wiscPkg::NOP: begin
                ctrl.nop = 1'b1;
            end
            // Accelerator kicks, held off while it is busy
            wiscPkg::STARTF: begin
                ctrl.startF = !fftCalculating;
                ctrl.blockInstruction = fftCalculating;
            end
            wiscPkg::STARTI: begin
                ctrl.startI = !fftCalculating;
                ctrl.blockInstruction = fftCalculating;
            end
            wiscPkg::LOADF: begin
                ctrl.loadF = 1'b1;
            end
            // I-type 1, immediate in bits 4:0
            wiscPkg::ADDI: begin
                ctrl.aluOp = wiscPkg::OP_ADD;
                ctrl.regWrite = 1'b1;
                ctrl.isIType1 = 1'b1;
                ctrl.isSignExtend = 1'b1;
            end
            wiscPkg::SUBI: begin
                ctrl.aluOp = wiscPkg::OP_SUB;
                ctrl.regWrite = 1'b1;
                ctrl.isIType1 = 1'b1;
                ctrl.isSignExtend = 1'b1;
            end
            // Logic immediates zero extend
            wiscPkg::XORI: begin
                ctrl.aluOp = wiscPkg::OP_XOR;
                ctrl.regWrite = 1'b1;
                ctrl.isIType1 = 1'b1;
            end
            wiscPkg::ANDNI: begin
                ctrl.aluOp = wiscPkg::OP_ANDN;
                ctrl.regWrite = 1'b1;
                ctrl.isIType1 = 1'b1;
            end
            // Memory ops, address is rs plus immediate
            wiscPkg::ST: begin
                ctrl.aluOp = wiscPkg::OP_ADD;
                ctrl.memWrite = 1'b1;
                ctrl.isIType1 = 1'b1;
                ctrl.isSignExtend = 1'b1;
            end
            wiscPkg::LD: begin
                ctrl.aluOp = wiscPkg::OP_ADD;
                ctrl.memRead = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.isIType1 = 1'b1;
                ctrl.isSignExtend = 1'b1;
            end
            // Store with base update into rs
            wiscPkg::STU: begin
                ctrl.aluOp = wiscPkg::OP_ADD;
                ctrl.memWrite = 1'b1;
                ctrl.rsWrite = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.isIType1 = 1'b1;
                ctrl.isSignExtend = 1'b1;
            end
            // R-type, second operand from rt
            wiscPkg::ADD, wiscPkg::SUB, wiscPkg::XOR, wiscPkg::ANDN,
            wiscPkg::SEQ, wiscPkg::SLT, wiscPkg::SLE: begin
                ctrl.regDst = 1'b1;
                ctrl.aluSrc = 1'b1;
                ctrl.regWrite = 1'b1;
                case (opcode)
                    wiscPkg::SUB:  ctrl.aluOp = wiscPkg::OP_SUB;
                    wiscPkg::XOR:  ctrl.aluOp = wiscPkg::OP_XOR;
                    wiscPkg::ANDN: ctrl.aluOp = wiscPkg::OP_ANDN;
                    wiscPkg::SEQ:  ctrl.aluOp = wiscPkg::OP_SEQ;
                    wiscPkg::SLT:  ctrl.aluOp = wiscPkg::OP_SLT;
                    wiscPkg::SLE:  ctrl.aluOp = wiscPkg::OP_SLE;
                    default:       ctrl.aluOp = wiscPkg::OP_ADD;
                endcase
            end
            // Branches test rs against zero
            wiscPkg::BEQZ: begin
                ctrl.isBranch = 1'b1;
                ctrl.aluOp = wiscPkg::OP_BEQZ;
            end
            wiscPkg::BNEZ: begin
                ctrl.isBranch = 1'b1;
                ctrl.aluOp = wiscPkg::OP_BNEZ;
            end
            wiscPkg::BLTZ: begin
                ctrl.isBranch = 1'b1;
                ctrl.aluOp = wiscPkg::OP_BLTZ;
            end
            wiscPkg::BGEZ: begin
                ctrl.isBranch = 1'b1;
                ctrl.aluOp = wiscPkg::OP_BGEZ;
            end
            // Byte immediates land in rs
            wiscPkg::LBI: begin
                ctrl.aluOp = wiscPkg::OP_LBI;
                ctrl.rsWrite = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            wiscPkg::SLBI: begin
                ctrl.aluOp = wiscPkg::OP_SLBI;
                ctrl.rsWrite = 1'b1;
                ctrl.isSLBI = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            // Jumps, the linking forms write r7
            wiscPkg::JR: begin
                ctrl.isJR = 1'b1;
            end
            wiscPkg::JALR: begin
                ctrl.isJAL = 1'b1;
                ctrl.isJR = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            wiscPkg::J: begin
                ctrl.isJump = 1'b1;
            end
            wiscPkg::JAL: begin
                ctrl.isJAL = 1'b1;
                ctrl.isJump = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            // Unmapped codes fall through as a nop
            default: begin
                ctrl = '0;
            end
        endcase
    end

    // One port on the data memory, never read and write together
    always_comb begin
        assert (!(ctrl.memRead && ctrl.memWrite))
            else $error("decode drives memRead and memWrite together");
    end

endmodule

`default_nettype wire

// File: design/wiscExecute.sv
`timescale 1ns/1ps
`default_nettype none

module wiscExecute (
    input  wiscPkg::ctrlT  ctrl,
    input  logic [15:0]    instr,
    input  logic [15:0]    rsValue,
    input  logic [15:0]    rtValue,
    input  logic [15:0]    pc,
    output wiscPkg::exResT exRes
);

    logic [15:0] opB;
    logic [15:0] imm5Ext;
    logic [15:0] imm8Sext;
    logic [15:0] imm8Zext;
    logic [15:0] disp11Sext;
    logic [15:0] pcPlus2;
    logic        cond;

    // Immediate extensions
    assign imm5Ext = ctrl.isSignExtend ? {{11{instr[4]}}, instr[4:0]} : {11'b0, instr[4:0]};
    assign imm8Sext = {{8{instr[7]}}, instr[7:0]};
    assign imm8Zext = {8'b0, instr[7:0]};
    assign disp11Sext = {{5{instr[10]}}, instr[10:0]};
    assign pcPlus2 = pc + 16'd2;

    // Operand B: rt, short immediate, or byte immediate
    always_comb begin
        if (ctrl.aluSrc) begin
            opB = rtValue;
        end else if (ctrl.isIType1) begin
            opB = imm5Ext;
        end else if (ctrl.isSLBI) begin
            // SLBI ORs in the raw byte
            opB = imm8Zext;
        end else begin
            opB = imm8Sext;
        end
    end

    always_comb begin
        exRes.aluResult = '0;
        case (ctrl.aluOp)
            wiscPkg::OP_ADD:  exRes.aluResult = rsValue + opB;
            wiscPkg::OP_SUB:  exRes.aluResult = rsValue - opB;
            wiscPkg::OP_XOR:  exRes.aluResult = rsValue ^ opB;
            wiscPkg::OP_ANDN: exRes.aluResult = rsValue & ~opB;
            // Set ops yield 1 or 0, signed compare
            wiscPkg::OP_SEQ:  exRes.aluResult = {15'b0, rsValue == opB};
            wiscPkg::OP_SLT:  exRes.aluResult = {15'b0, $signed(rsValue) < $signed(opB)};
            wiscPkg::OP_SLE:  exRes.aluResult = {15'b0, $signed(rsValue) <= $signed(opB)};
            wiscPkg::OP_LBI:  exRes.aluResult = opB;
            wiscPkg::OP_SLBI: exRes.aluResult = {rsValue[7:0], 8'b0} | opB;
            default:          exRes.aluResult = rsValue;
        endcase
    end

    // Branch condition on rs against zero
    always_comb begin
        case (ctrl.aluOp)
            wiscPkg::OP_BEQZ: cond = (rsValue == 16'd0);
            wiscPkg::OP_BNEZ: cond = (rsValue != 16'd0);
            wiscPkg::OP_BLTZ: cond = rsValue[15];
            wiscPkg::OP_BGEZ: cond = !rsValue[15];
            default:          cond = 1'b0;
        endcase
    end

    assign exRes.branchTaken = ctrl.isBranch && cond;
    assign exRes.linkValue = pcPlus2;

    // Next PC, register jumps first
    always_comb begin
        if (ctrl.isJR) begin
            exRes.nextPc = rsValue + imm8Sext;
        end else if (ctrl.isJump) begin
            exRes.nextPc = pcPlus2 + disp11Sext;
        end else if (exRes.branchTaken) begin
            exRes.nextPc = pcPlus2 + imm8Sext;
        end else begin
            exRes.nextPc = pcPlus2;
        end
    end

endmodule

`default_nettype wire

// File: design/wiscPkg.sv
`default_nettype none

package wiscPkg;

    // Datapath sizes
    localparam int dataWidth = 16;
    localparam int numRegs = 8;
    localparam int regIdxW = 3;
    // Memory index comes from word address bits 4:1
    localparam int memWords = 16;
    localparam int memAddrW = 4;

    // APB address map
    localparam int addrW = 8;
    localparam logic [7:0] addrIssue = 8'h00;
    // Register r lives at addrRegBase + 4*r
    localparam logic [7:0] addrRegBase = 8'h20;
    localparam logic [7:0] addrPc = 8'h40;
    localparam logic [7:0] addrStatus = 8'h44;

    // Opcode map, bits 15:11 of the instruction
    typedef enum logic [4:0] {
        HALT   = 5'b00000,
        NOP    = 5'b00001,
        STARTF = 5'b00010,
        STARTI = 5'b00011,
        J      = 5'b00100,
        JR     = 5'b00101,
        JAL    = 5'b00110,
        JALR   = 5'b00111,
        ADDI   = 5'b01000,
        SUBI   = 5'b01001,
        XORI   = 5'b01010,
        ANDNI  = 5'b01011,
        BEQZ   = 5'b01100,
        BNEZ   = 5'b01101,
        BLTZ   = 5'b01110,
        BGEZ   = 5'b01111,
        ST     = 5'b10000,
        LD     = 5'b10001,
        SLBI   = 5'b10010,
        STU    = 5'b10011,
        LBI    = 5'b10100,
        ADD    = 5'b11000,
        SUB    = 5'b11001,
        XOR    = 5'b11010,
        ANDN   = 5'b11011,
        SEQ    = 5'b11100,
        SLT    = 5'b11101,
        SLE    = 5'b11110,
        LOADF  = 5'b11111
    } opcodeE;

    // ALU operation select
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_XOR  = 4'd2,
        OP_ANDN = 4'd3,
        OP_BEQZ = 4'd4,
        OP_BNEZ = 4'd5,
        OP_BLTZ = 4'd6,
        OP_BGEZ = 4'd7,
        OP_SEQ  = 4'd8,
        OP_SLT  = 4'd9,
        OP_SLE  = 4'd10,
        OP_LBI  = 4'd11,
        OP_SLBI = 4'd12
    } aluOpE;

    // Decoded control word
    typedef struct packed {
        logic isJAL;
        logic regDst;
        logic rsWrite;
        logic regWrite;
        logic aluSrc;
        logic isSignExtend;
        logic isIType1;
        logic isBranch;
        logic halt;
        logic nop;
        logic memWrite;
        logic memRead;
        logic memToReg;
        logic isJR;
        logic isSLBI;
        aluOpE aluOp;
        logic isJump;
        logic startI;
        logic startF;
        logic loadF;
        logic blockInstruction;
    } ctrlT;

    // Execute stage result
    typedef struct packed {
        logic [dataWidth-1:0] aluResult;
        logic branchTaken;
        logic [dataWidth-1:0] nextPc;
        logic [dataWidth-1:0] linkValue;
    } exResT;

endpackage

`default_nettype wire

// File: design/wiscResult.sv
`timescale 1ns/1ps
`default_nettype none

module wiscResult (
    input  logic           clk,
    input  logic           arstN,
    input  logic           commit,
    input  wiscPkg::ctrlT  ctrl,
    input  logic [15:0]    instr,
    input  wiscPkg::exResT exRes,
    output logic [15:0]    rsValue,
    output logic [15:0]    rtValue,
    input  logic [2:0]     readIdx,
    output logic [15:0]    readValue,
    output logic [15:0]    pc,
    output logic           halted,
    output logic           lastTaken
);

    logic [wiscPkg::dataWidth-1:0] regs [wiscPkg::numRegs];
    logic [wiscPkg::dataWidth-1:0] mem [wiscPkg::memWords];
    logic [wiscPkg::regIdxW-1:0]   wrIdx;
    logic [wiscPkg::memAddrW-1:0]  memAddr;
    logic [15:0]                   memData;
    logic [15:0]                   wrData;
    logic                          regWe;

    // Source operands, rs in 10:8 and rt in 7:5
    assign rsValue = regs[instr[10:8]];
    assign rtValue = regs[instr[7:5]];
    // Host-side read port
    assign readValue = regs[readIdx];

    // Word address from the byte address
    assign memAddr = exRes.aluResult[wiscPkg::memAddrW:1];
    assign memData = ctrl.memRead ? mem[memAddr] : '0;

    // Destination select
    always_comb begin
        if (ctrl.isJAL) begin
            wrIdx = 3'd7;
        end else if (ctrl.rsWrite) begin
            wrIdx = instr[10:8];
        end else if (ctrl.regDst) begin
            wrIdx = instr[4:2];
        end else begin
            wrIdx = instr[7:5];
        end
    end

    assign wrData = ctrl.isJAL ? exRes.linkValue : (ctrl.memToReg ? memData : exRes.aluResult);
    // NOP never touches the register file
    assign regWe = commit && ctrl.regWrite && !ctrl.nop;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < wiscPkg::numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (regWe) begin
            regs[wrIdx] <= wrData;
        end
    end

    // ST and STU store the I-type rd value
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < wiscPkg::memWords; i++) begin
                mem[i] <= '0;
            end
        end else if (commit && ctrl.memWrite) begin
            mem[memAddr] <= rtValue;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
            halted <= 1'b0;
            lastTaken <= 1'b0;
        end else if (commit) begin
            // HALT keeps the PC where it is
            if (!ctrl.halt) begin
                pc <= exRes.nextPc;
            end
            if (ctrl.halt) begin
                halted <= 1'b1;
            end
            lastTaken <= exRes.branchTaken;
        end
    end

    // Top level must hold off commits once halted
    assert property (@(posedge clk) disable iff (!arstN) halted |-> !commit)
        else $error("commit while halted");

endmodule

`default_nettype wire

// File: dv/tb.sv
`timescale 1ns/1ps
`default_nettype none

module tb;

    // Rough transfer budget per test, used by the watchdog
    localparam int numXfers = 16 + 200 * 2 + 40 * 4 + 40 * 5 + 40 + 30;

    logic        clk;
    logic        arstN;
    logic        PSEL;
    logic        PENABLE;
    logic        PWRITE;
    logic [7:0]  PADDR;
    logic [15:0] PWDATA;
    logic [15:0] PRDATA;
    logic        PREADY;
    logic        PSLVERR;
    logic        fftBusy;
    logic        startF;
    logic        startI;
    logic        loadF;

    logic [31:0] lfsr;
    int          busyLeft;
    int          cntStartF;
    int          cntStartI;
    int          cntLoadF;
    int          errors;
    int          checks;
    int          errStart;
    int          testsRun;
    int          testsFailed;
    string       testName;

    // Reference state
    logic [15:0] modelRegs [8];
    logic [15:0] modelMem [16];
    logic [15:0] modelPc;
    logic        modelHalted;
    logic        modelTaken;

    wiscCoreTop uut (
        .clk     (clk),
        .arstN   (arstN),
        .PSEL    (PSEL),
        .PENABLE (PENABLE),
        .PWRITE  (PWRITE),
        .PADDR   (PADDR),
        .PWDATA  (PWDATA),
        .PRDATA  (PRDATA),
        .PREADY  (PREADY),
        .PSLVERR (PSLVERR),
        .fftBusy (fftBusy),
        .startF  (startF),
        .startI  (startI),
        .loadF   (loadF)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Galois LFSR, taps 32 22 2 1
    function automatic logic [31:0] stepLfsr(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [15:0] randBits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = stepLfsr(lfsr);
            v = {v[14:0], lfsr[0]};
        end
        return v;
    endfunction

    // Pulse counters, sampled mid-cycle
    always @(negedge clk) begin
        if (startF) cntStartF++;
        if (startI) cntStartI++;
        if (loadF) cntLoadF++;
        if ((startF || startI || loadF) && (!PREADY || fftBusy)) begin
            $display("Accelerator pulse outside a completing transfer in test %s", testName);
            errors++;
        end
    end

    // Accelerator busy countdown, one step per waited cycle
    task automatic tickBusy();
        if (busyLeft > 0) begin
            busyLeft--;
            if (busyLeft == 0) fftBusy = 1'b0;
        end
    endtask

    // Full APB transfer, entered and left 2 ns after a rising edge
    task automatic apbXfer(input logic wr, input logic [7:0] addr, input logic [15:0] wdata,
                           output logic [15:0] rdata, output logic err, output int waits);
        waits = 0;
        PSEL = 1'b1;
        PENABLE = 1'b0;
        PWRITE = wr;
        PADDR = addr;
        PWDATA = wdata;
        @(posedge clk);
        #2;
        PENABLE = 1'b1;
        @(negedge clk);
        while (!PREADY) begin
            waits++;
            @(posedge clk);
            #2;
            tickBusy();
            @(negedge clk);
        end
        rdata = PRDATA;
        err = PSLVERR;
        @(posedge clk);
        #2;
        PSEL = 1'b0;
        PENABLE = 1'b0;
    endtask

    task automatic expectValue(input string what, input logic [15:0] exp,
                               input logic [15:0] act);
        checks++;
        if (exp !== act) begin
            $display("MISMATCH %s %s expected %h actual %h", testName, what, exp, act);
            errors++;
        end
    endtask

    // Reference execution of one instruction
    task automatic modelIssue(input logic [15:0] ins);
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] i5s;
        logic [15:0] i5z;
        logic [15:0] i8s;
        logic [15:0] pc2;
        logic [15:0] addr;
        logic [15:0] next;
        logic        taken;
        int          rs;
        int          rdR;
        int          rdI;
        rs = ins[10:8];
        rdR = ins[4:2];
        rdI = ins[7:5];
        a = modelRegs[rs];
        b = modelRegs[ins[7:5]];
        i5s = {{11{ins[4]}}, ins[4:0]};
        i5z = {11'b0, ins[4:0]};
        i8s = {{8{ins[7]}}, ins[7:0]};
        pc2 = modelPc + 16'd2;
        addr = a + i5s;
        next = pc2;
        taken = 1'b0;
        case (ins[15:11])
            wiscPkg::ADD:   modelRegs[rdR] = a + b;
            wiscPkg::SUB:   modelRegs[rdR] = a - b;
            wiscPkg::XOR:   modelRegs[rdR] = a ^ b;
            wiscPkg::ANDN:  modelRegs[rdR] = a & ~b;
            wiscPkg::SEQ:   modelRegs[rdR] = {15'b0, a == b};
            wiscPkg::SLT:   modelRegs[rdR] = {15'b0, $signed(a) < $signed(b)};
            wiscPkg::SLE:   modelRegs[rdR] = {15'b0, $signed(a) <= $signed(b)};
            wiscPkg::ADDI:  modelRegs[rdI] = a + i5s;
            wiscPkg::SUBI:  modelRegs[rdI] = a - i5s;
            wiscPkg::XORI:  modelRegs[rdI] = a ^ i5z;
            wiscPkg::ANDNI: modelRegs[rdI] = a & ~i5z;
            wiscPkg::ST:    modelMem[addr[4:1]] = modelRegs[rdI];
            wiscPkg::LD:    modelRegs[rdI] = modelMem[addr[4:1]];
            // Store the old rd value, then the base update
            wiscPkg::STU: begin
                modelMem[addr[4:1]] = modelRegs[rdI];
                modelRegs[rs] = addr;
            end
            wiscPkg::LBI:   modelRegs[rs] = i8s;
            wiscPkg::SLBI:  modelRegs[rs] = {a[7:0], ins[7:0]};
            wiscPkg::BEQZ:  taken = (a == 16'd0);
            wiscPkg::BNEZ:  taken = (a != 16'd0);
            wiscPkg::BLTZ:  taken = a[15];
            wiscPkg::BGEZ:  taken = !a[15];
            wiscPkg::J:     next = pc2 + {{5{ins[10]}}, ins[10:0]};
            wiscPkg::JAL: begin
                next = pc2 + {{5{ins[10]}}, ins[10:0]};
                modelRegs[7] = pc2;
            end
            wiscPkg::JR:    next = a + i8s;
            wiscPkg::JALR: begin
                next = a + i8s;
                modelRegs[7] = pc2;
            end
            wiscPkg::HALT: begin
                modelHalted = 1'b1;
                next = modelPc;
            end
            default: ;
        endcase
        if (taken) next = pc2 + i8s;
        modelPc = next;
        modelTaken = taken;
    endtask

    // Issue write; PSLVERR expected only once halted
    task automatic issue(input logic [15:0] ins, output int waits);
        logic [15:0] rd;
        logic        err;
        apbXfer(1'b1, wiscPkg::addrIssue, ins, rd, err, waits);
        expectValue("pslverr on issue", {15'b0, modelHalted}, {15'b0, err});
        if (!modelHalted) modelIssue(ins);
    endtask

    task automatic checkReg(input logic [2:0] r);
        logic [15:0] rd;
        logic        err;
        int          waits;
        apbXfer(1'b0, wiscPkg::addrRegBase + {3'b0, r, 2'b00}, 16'h0, rd, err, waits);
        expectValue($sformatf("r%0d", r), modelRegs[r], rd);
    endtask

    task automatic checkPcStatus();
        logic [15:0] rd;
        logic        err;
        int          waits;
        apbXfer(1'b0, wiscPkg::addrPc, 16'h0, rd, err, waits);
        expectValue("pc", modelPc, rd);
        apbXfer(1'b0, wiscPkg::addrStatus, 16'h0, rd, err, waits);
        expectValue("status", {14'b0, modelTaken, modelHalted}, rd);
    endtask

    task automatic startTest(input string name);
        testName = name;
        errStart = errors;
    endtask

    task automatic finishTest();
        testsRun++;
        if (errors == errStart) begin
            $display("test %s: ok", testName);
        end else begin
            testsFailed++;
            $display("test %s: failed with %0d errors", testName, errors - errStart);
        end
    endtask

    // Watchdog sized from the transfer budget
    initial begin
        repeat (numXfers * 20 + 500) @(posedge clk);
        $display("Timeout: the run did not finish in the expected number of cycles");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        logic [4:0]  arithOps [11];
        logic [4:0]  memOps [3];
        logic [4:0]  flowOps [8];
        logic [4:0]  op;
        logic [2:0]  rs;
        logic [2:0]  rd;
        logic [15:0] ins;
        logic [15:0] rdata;
        logic        err;
        int          waits;
        int          n;
        int          f0;
        int          i0;
        int          l0;
        arithOps = '{wiscPkg::ADD, wiscPkg::SUB, wiscPkg::XOR, wiscPkg::ANDN, wiscPkg::SEQ,
                     wiscPkg::SLT, wiscPkg::SLE, wiscPkg::ADDI, wiscPkg::SUBI,
                     wiscPkg::XORI, wiscPkg::ANDNI};
        memOps = '{wiscPkg::ST, wiscPkg::LD, wiscPkg::STU};
        flowOps = '{wiscPkg::BEQZ, wiscPkg::BNEZ, wiscPkg::BLTZ, wiscPkg::BGEZ,
                    wiscPkg::J, wiscPkg::JAL, wiscPkg::JR, wiscPkg::JALR};
        lfsr = 32'h1bc7_7efc;
        arstN = 1'b0;
        PSEL = 1'b0;
        PENABLE = 1'b0;
        PWRITE = 1'b0;
        PADDR = '0;
        PWDATA = '0;
        fftBusy = 1'b0;
        busyLeft = 0;
        cntStartF = 0;
        cntStartI = 0;
        cntLoadF = 0;
        errors = 0;
        checks = 0;
        testsRun = 0;
        testsFailed = 0;
        testName = "reset";
        for (int i = 0; i < 8; i++) modelRegs[i] = '0;
        for (int i = 0; i < 16; i++) modelMem[i] = '0;
        modelPc = '0;
        modelHalted = 1'b0;
        modelTaken = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        arstN = 1'b1;

        // Byte loads seed every register
        startTest("arith");
        for (int r = 0; r < 8; r++) begin
            issue({wiscPkg::LBI, 3'(r), 8'(randBits(8))}, waits);
            issue({wiscPkg::SLBI, 3'(r), 8'(randBits(8))}, waits);
            checkReg(3'(r));
        end
        for (int k = 0; k < 200; k++) begin
            op = arithOps[randBits(4) % 11];
            ins = {op, 11'(randBits(11))};
            if (op[4:3] == 2'b11) ins[1:0] = 2'b00;
            issue(ins, waits);
            // R-type writes bits 4:2, I-type bits 7:5
            checkReg(op[4:3] == 2'b11 ? ins[4:2] : ins[7:5]);
        end
        finishTest();

        // Small base addresses loaded just before each access
        startTest("memory");
        for (int k = 0; k < 40; k++) begin
            op = memOps[randBits(2) % 3];
            rs = 3'(randBits(3));
            rd = 3'(randBits(3));
            issue({wiscPkg::LBI, rs, 3'b0, 5'(randBits(5))}, waits);
            issue({op, rs, rd, 5'(randBits(5))}, waits);
            checkReg(rd);
            checkReg(rs);
        end
        finishTest();

        // Base register zero about half the time
        startTest("flow");
        for (int k = 0; k < 40; k++) begin
            op = flowOps[randBits(3)];
            rs = 3'(randBits(3));
            issue({wiscPkg::LBI, rs, (randBits(1) ? 8'(randBits(8)) : 8'h00)}, waits);
            if (op == wiscPkg::J || op == wiscPkg::JAL) begin
                ins = {op, 11'(randBits(11))};
            end else begin
                ins = {op, rs, 8'(randBits(8))};
            end
            issue(ins, waits);
            checkPcStatus();
            checkReg(3'd7);
        end
        finishTest();

        // Even rounds run with the accelerator idle, odd rounds busy
        startTest("accel");
        for (int k = 0; k < 8; k++) begin
            op = k[1] ? wiscPkg::STARTI : wiscPkg::STARTF;
            n = 0;
            if (k[0]) begin
                n = 1 + randBits(3);
                fftBusy = 1'b1;
                busyLeft = n;
            end
            f0 = cntStartF;
            i0 = cntStartI;
            issue({op, 11'h0}, waits);
            expectValue("wait cycles", 16'(n), 16'(waits));
            expectValue("startF pulses", {15'b0, !k[1]}, 16'(cntStartF - f0));
            expectValue("startI pulses", {15'b0, k[1]}, 16'(cntStartI - i0));
        end
        l0 = cntLoadF;
        issue({wiscPkg::LOADF, 11'h0}, waits);
        expectValue("loadF pulses", 16'd1, 16'(cntLoadF - l0));
        checkPcStatus();
        finishTest();

        startTest("halt");
        apbXfer(1'b0, 8'h10, 16'h0, rdata, err, waits);
        expectValue("pslverr on bad read", 16'd1, {15'b0, err});
        apbXfer(1'b0, 8'h21, 16'h0, rdata, err, waits);
        expectValue("pslverr on unaligned read", 16'd1, {15'b0, err});
        apbXfer(1'b1, wiscPkg::addrPc, randBits(16), rdata, err, waits);
        expectValue("pslverr on pc write", 16'd1, {15'b0, err});
        issue({wiscPkg::HALT, 11'h0}, waits);
        checkPcStatus();
        // Frozen core rejects every issue
        for (int k = 0; k < 5; k++) begin
            issue({arithOps[randBits(4) % 11], 11'(randBits(11))}, waits);
        end
        for (int r = 0; r < 8; r++) checkReg(3'(r));
        checkPcStatus();
        finishTest();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 testsRun, testsFailed, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
design/wiscPkg.sv
design/wiscDecode.sv
design/wiscExecute.sv
design/wiscResult.sv
design/wiscCoreTop.sv
dv/tb.sv
